//--- ext_mem_defines.svh
`ifndef EXT_MEM_DEFINES_SVH
`define EXT_MEM_DEFINES_SVH

// byte address width seen on the bus
`define EM_ADDR_W        8
// byte lanes per memory word
`define EM_NUM_BYTES     4
`define EM_BYTE_W        8
`define EM_DATA_W        (`EM_NUM_BYTES * `EM_BYTE_W)

// low address bits that pick a byte inside a word
`define EM_BYTE_SEL_W    $clog2(`EM_NUM_BYTES)
`define EM_WORD_ADDR_W   (`EM_ADDR_W - `EM_BYTE_SEL_W)
`define EM_NUM_WORDS     64

// edges from read sample to data on the bus, never below 1
`define EM_READ_LATENCY  2

`endif

//--- ext_mem_pkg.sv
`default_nettype none

`include "ext_mem_defines.svh"

package ext_mem_pkg;

   // one memory word, seen whole or lane by lane
   typedef union packed {
      logic [`EM_DATA_W-1:0]                     word;
      logic [`EM_NUM_BYTES-1:0][`EM_BYTE_W-1:0]  bytes;
   } mem_word_u;

   // --------------------------------------------------
   // raw conduit bus as driven from outside
   // --------------------------------------------------
   typedef struct packed {
      logic [`EM_ADDR_W-1:0]     address;
      logic                      chipselect;
      logic                      read;
      logic                      write;
      logic                      outputenable;
      logic [`EM_NUM_BYTES-1:0]  byteenable;
   } conduit_bus_t;

   // --------------------------------------------------
   // decoded command shared by storage and read pipe
   // --------------------------------------------------
   typedef struct packed {
      logic [`EM_WORD_ADDR_W-1:0]  word_addr;
      // read that is allowed to drive the bus later
      logic                        rd_issue;
      logic                        wr_en;
      // byte enables spread over every bit of their lane
      logic [`EM_DATA_W-1:0]       byte_mask;
      logic [`EM_NUM_BYTES-1:0]    byte_en;
   } mem_cmd_t;

endpackage

`default_nettype wire

//--- cmd_decode.sv
`default_nettype none

`include "ext_mem_defines.svh"

module cmd_decode (
   input  wire ext_mem_pkg::conduit_bus_t  bus,
   output ext_mem_pkg::mem_cmd_t           cmd
);

   // --------------------------------------------------
   // address and strobes
   // --------------------------------------------------
   always_comb begin
      // byte select bits are dropped, the lanes come from byteenable
      cmd.word_addr = bus.address[`EM_ADDR_W-1:`EM_BYTE_SEL_W];

      // a read only counts when the bus will let us drive data back
      cmd.rd_issue  = bus.chipselect & bus.read & bus.outputenable;

      // write needs chip select only, output enable plays no part
      cmd.wr_en     = bus.chipselect & bus.write;

      cmd.byte_en   = bus.byteenable;
   end

   // --------------------------------------------------
   // byte enable to bit mask
   // --------------------------------------------------
   always_comb begin
      // each enable fills the whole width of its lane
      for (int i = 0; i < `EM_NUM_BYTES; i++) begin
         cmd.byte_mask[i*`EM_BYTE_W +: `EM_BYTE_W] = {`EM_BYTE_W{bus.byteenable[i]}};
      end
   end

   // --------------------------------------------------
   // bus protocol check
   // --------------------------------------------------
   // read and write together under chip select is legal here
   // the write wins and any read returns the old word
   // so this only warns about a suspicious master
   always_comb begin
      if (bus.chipselect) begin
         assert (!(bus.read && bus.write))
            else $warning("cmd_decode: read and write both high, addr 0x%0h",
                          bus.address);
      end
   end

endmodule

`default_nettype wire

//--- mem_array.sv
`default_nettype none

`include "ext_mem_defines.svh"

module mem_array (
   input  wire logic                    clk,
   input  wire logic                    internal_reset,
   input  wire ext_mem_pkg::mem_cmd_t   cmd,
   input  wire ext_mem_pkg::mem_word_u  data_in,
   output ext_mem_pkg::mem_word_u       rd_word
);

   import ext_mem_pkg::*;

   // --------------------------------------------------
   // storage
   // --------------------------------------------------
   mem_word_u mem [`EM_NUM_WORDS];

   // whole array goes back to zero on reset
   // a write only touches the lanes that are enabled
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int w = 0; w < `EM_NUM_WORDS; w++) begin
            mem[w] <= '0;
         end
      end else if (cmd.wr_en) begin
         // merge lane by lane through the byte view
         for (int b = 0; b < `EM_NUM_BYTES; b++) begin
            if (cmd.byte_en[b]) begin
               mem[cmd.word_addr].bytes[b] <= data_in.bytes[b];
            end
         end
      end
   end

   // --------------------------------------------------
   // read port
   // --------------------------------------------------
   // combinational, so a write on this edge is not seen yet
   // the read pipe captures the old word on a shared edge
   assign rd_word = mem[cmd.word_addr];

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // an unknown address would smear the write over unknown words
   // and the cleared contents could no longer be trusted
   a_wr_addr_known : assert property (
      @(posedge clk) disable iff (internal_reset)
      cmd.wr_en |-> !$isunknown(cmd.word_addr)
   ) else $error("mem_array: write with unknown word address");

endmodule

`default_nettype wire

//--- read_pipe.sv
`default_nettype none

`include "ext_mem_defines.svh"

module read_pipe (
   input  wire logic                    clk,
   input  wire logic                    internal_reset,
   input  wire ext_mem_pkg::mem_cmd_t   cmd,
   input  wire ext_mem_pkg::mem_word_u  rd_word,
   output ext_mem_pkg::mem_word_u       data_out,
   output logic                         data_oe
);

   import ext_mem_pkg::*;

   localparam int LAT = `EM_READ_LATENCY;

   // --------------------------------------------------
   // pipeline stages
   // --------------------------------------------------
   // stage 0 is the capture stage and stage LAT-1 faces the bus
   logic [LAT-1:0]  stage_vld;
   mem_word_u       stage_data [LAT];

   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         stage_vld <= '0;
         // payload cleared too so the bus reads zero during reset
         for (int s = 0; s < LAT; s++) begin
            stage_data[s] <= '0;
         end
      end else begin
         stage_vld[0] <= cmd.rd_issue;

         // disabled lanes read back as zero
         // an empty slot carries zero so the output needs no mux
         if (cmd.rd_issue) begin
            stage_data[0].word <= rd_word.word & cmd.byte_mask;
         end else begin
            stage_data[0].word <= '0;
         end

         // plain shift so a new read may enter every cycle
         for (int s = 1; s < LAT; s++) begin
            stage_vld[s]  <= stage_vld[s-1];
            stage_data[s] <= stage_data[s-1];
         end
      end
   end

   // --------------------------------------------------
   // bus side
   // --------------------------------------------------
   assign data_oe  = stage_vld[LAT-1];
   assign data_out = stage_data[LAT-1];

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // zero fill of empty slots has to hold through every stage
   a_idle_zero : assert property (
      @(posedge clk) disable iff (internal_reset)
      !data_oe |-> (data_out.word == '0)
   ) else $error("read_pipe: data_out not zero while data_oe low");

endmodule

`default_nettype wire

//--- ext_mem_top.sv
`default_nettype none

module ext_mem_top (
   input  wire logic                       clk,
   input  wire logic                       internal_reset,
   input  wire ext_mem_pkg::conduit_bus_t  bus,
   input  wire ext_mem_pkg::mem_word_u     data_in,
   output ext_mem_pkg::mem_word_u          data_out,
   output logic                            data_oe
);

   import ext_mem_pkg::*;

   // --------------------------------------------------
   // internal wiring
   // --------------------------------------------------
   // decoded command fans out to storage and read pipe
   mem_cmd_t   cmd;
   // stored word at the current address, before this edge's write
   mem_word_u  rd_word;

   // --------------------------------------------------
   // bus decode
   // --------------------------------------------------
   cmd_decode i_cmd_decode (
      .bus (bus),
      .cmd (cmd)
   );

   // --------------------------------------------------
   // storage
   // --------------------------------------------------
   mem_array i_mem_array (
      .clk            (clk),
      .internal_reset (internal_reset),
      .cmd            (cmd),
      .data_in        (data_in),
      .rd_word        (rd_word)
   );

   // --------------------------------------------------
   // read latency and output drive
   // --------------------------------------------------
   read_pipe i_read_pipe (
      .clk            (clk),
      .internal_reset (internal_reset),
      .cmd            (cmd),
      .rd_word        (rd_word),
      .data_out       (data_out),
      .data_oe        (data_oe)
   );

endmodule

`default_nettype wire

//--- tb_ext_mem.sv
`default_nettype none

`include "ext_mem_defines.svh"

module tb_ext_mem;

   timeunit 1ns;
   timeprecision 1ps;

   import ext_mem_pkg::*;

   localparam int LAT          = `EM_READ_LATENCY;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_OPS      = 400;
   // directed section stays well below this
   localparam int DIR_BUDGET   = 80;
   localparam int DRAIN_CYCLES = LAT + 4;
   // whole run length plus headroom
   localparam int MAX_CYCLES   = RESET_CYCLES + DIR_BUDGET + NUM_OPS + DRAIN_CYCLES + 100;

   logic          clk = 1'b0;
   logic          internal_reset = 1'b1;
   conduit_bus_t  bus;
   mem_word_u     data_in;
   mem_word_u     data_out;
   logic          data_oe;

   // --------------------------------------------------
   // reference model state
   // --------------------------------------------------
   logic [`EM_DATA_W-1:0]  model_mem [`EM_NUM_WORDS];
   // expected read words and the edge each read was issued on
   logic [`EM_DATA_W-1:0]  exp_q [$];
   int                     exp_edge_q [$];
   int                     edge_cnt  = 0;
   int                     cycle_cnt = 0;
   int                     data_errs = 0;
   int                     oe_errs   = 0;
   int                     idle_errs = 0;
   integer                 seed;

   ext_mem_top i_ext_mem_top (
      .clk            (clk),
      .internal_reset (internal_reset),
      .bus            (bus),
      .data_in        (data_in),
      .data_out       (data_out),
      .data_oe        (data_oe)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // every enabled byte lane opens all of its bits
   function automatic logic [`EM_DATA_W-1:0] lane_mask(input logic [`EM_NUM_BYTES-1:0] be);
      logic [`EM_DATA_W-1:0] m;
      m = '0;
      for (int b = 0; b < `EM_NUM_BYTES; b++) begin
         if (be[b]) begin
            m[b*`EM_BYTE_W +: `EM_BYTE_W] = '1;
         end
      end
      return m;
   endfunction

   // enabled lanes take the new byte, the rest keep the old one
   function automatic logic [`EM_DATA_W-1:0] merge_write(input logic [`EM_DATA_W-1:0] old_w,
                                                         input logic [`EM_DATA_W-1:0] new_w,
                                                         input logic [`EM_NUM_BYTES-1:0] be);
      logic [`EM_DATA_W-1:0] m;
      m = lane_mask(be);
      return (old_w & ~m) | (new_w & m);
   endfunction

   // --------------------------------------------------
   // model update on the rising edge
   // --------------------------------------------------
   always @(posedge clk) begin : model_update
      logic [`EM_WORD_ADDR_W-1:0] wa;
      if (internal_reset) begin
         for (int w = 0; w < `EM_NUM_WORDS; w++) begin
            model_mem[w] = '0;
         end
         exp_q.delete();
         exp_edge_q.delete();
         edge_cnt = 0;
      end else begin
         edge_cnt++;
         wa = bus.address[`EM_ADDR_W-1:`EM_BYTE_SEL_W];
         // read sees the word before this edge's write
         if (bus.chipselect && bus.read && bus.outputenable) begin
            exp_q.push_back(model_mem[wa] & lane_mask(bus.byteenable));
            exp_edge_q.push_back(edge_cnt);
         end
         if (bus.chipselect && bus.write) begin
            model_mem[wa] = merge_write(model_mem[wa], data_in.word, bus.byteenable);
         end
      end
   end

   // --------------------------------------------------
   // output checks on the falling edge
   // --------------------------------------------------
   always @(negedge clk) begin : output_check
      logic                   exp_oe;
      logic [`EM_DATA_W-1:0]  exp_word;
      int                     issued;
      exp_oe = 1'b0;
      // head of the queue is due LAT-1 edges after its issue edge
      if (exp_q.size() > 0) begin
         exp_oe = (exp_edge_q[0] + LAT - 1 == edge_cnt);
      end
      assert (data_oe == exp_oe) else begin
         $display("[ERROR] %0t data_oe expected %0b got %0b", $time, exp_oe, data_oe);
         oe_errs++;
      end
      if (exp_oe) begin
         exp_word = exp_q.pop_front();
         issued   = exp_edge_q.pop_front();
         if (data_oe) begin
            assert (data_out.word == exp_word) else begin
               $display("[ERROR] %0t data_out expected 0x%08h got 0x%08h (issued edge %0d)",
                        $time, exp_word, data_out.word, issued);
               data_errs++;
            end
         end
      end else if (!data_oe) begin
         // bus must be quiet between reads
         assert (data_out.word == '0) else begin
            $display("[ERROR] %0t data_out expected 0x%08h got 0x%08h",
                     $time, {`EM_DATA_W{1'b0}}, data_out.word);
            idle_errs++;
         end
      end
   end

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   task automatic drive_cmd(input logic cs, input logic rd, input logic wr, input logic oe,
                            input logic [`EM_ADDR_W-1:0] addr,
                            input logic [`EM_NUM_BYTES-1:0] be,
                            input logic [`EM_DATA_W-1:0] din);
      @(negedge clk);
      bus.address      = addr;
      bus.chipselect   = cs;
      bus.read         = rd;
      bus.write        = wr;
      bus.outputenable = oe;
      bus.byteenable   = be;
      data_in.word     = din;
   endtask

   task automatic drive_idle(input int n);
      repeat (n) drive_cmd(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
   endtask

   task automatic write_at(input logic [`EM_ADDR_W-1:0] addr,
                           input logic [`EM_NUM_BYTES-1:0] be,
                           input logic [`EM_DATA_W-1:0] din);
      drive_cmd(1'b1, 1'b0, 1'b1, 1'b1, addr, be, din);
   endtask

   task automatic read_at(input logic [`EM_ADDR_W-1:0] addr,
                          input logic [`EM_NUM_BYTES-1:0] be);
      drive_cmd(1'b1, 1'b1, 1'b0, 1'b1, addr, be, '0);
   endtask

   // run length guard
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("errors: data %0d, data_oe %0d, idle data %0d",
                  data_errs, oe_errs, idle_errs);
         $display("Test failures found");
         $finish;
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      logic [31:0]                r;
      logic [`EM_ADDR_W-1:0]      addr;
      logic [`EM_NUM_BYTES-1:0]   be;
      logic                       cs;
      logic                       rd;
      logic                       wr;
      logic                       oe;
      seed           = 32'h7790;
      bus            = '0;
      data_in        = '0;
      internal_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      internal_reset = 1'b0;
      drive_idle(2);

      // cleared memory reads back as zero
      read_at(8'h00, 4'hF);
      read_at(8'h7C, 4'hF);
      read_at(8'hFD, 4'hF);

      // full words, then back to back reads
      for (int w = 0; w < 8; w++) begin
         r = $random(seed);
         write_at(`EM_ADDR_W'(w * `EM_NUM_BYTES), 4'hF, r);
      end
      for (int w = 0; w < 8; w++) begin
         read_at(`EM_ADDR_W'(w * `EM_NUM_BYTES), 4'hF);
      end

      // partial writes merge lane by lane
      for (int w = 0; w < 4; w++) begin
         r = $random(seed);
         write_at(`EM_ADDR_W'(w * `EM_NUM_BYTES), r[3:0], $random(seed));
         read_at(`EM_ADDR_W'(w * `EM_NUM_BYTES), 4'hF);
      end

      // partial read lanes come back zero
      for (int w = 0; w < 4; w++) begin
         r = $random(seed);
         read_at(`EM_ADDR_W'(w * `EM_NUM_BYTES + 1), r[3:0]);
      end

      // no chip select, then no output enable
      drive_cmd(1'b0, 1'b1, 1'b0, 1'b1, 8'h04, 4'hF, '0);
      drive_cmd(1'b1, 1'b1, 1'b0, 1'b0, 8'h08, 4'hF, '0);
      drive_idle(LAT + 1);

      // same edge read and write, old word first
      drive_cmd(1'b1, 1'b1, 1'b1, 1'b1, 8'h10, 4'hF, 32'hCAFE_F00D);
      read_at(8'h10, 4'hF);
      drive_idle(2);

      // random mix, half the time kept to the low 16 words for hits
      for (int i = 0; i < NUM_OPS; i++) begin
         r    = $random(seed);
         addr = r[23] ? r[7:0] : {2'b00, r[5:0]};
         be   = r[11:8];
         cs   = (r[15:12] != 4'd0);
         oe   = (r[17:16] != 2'd0);
         wr   = r[18];
         rd   = !r[18] || (r[19] && r[20]);
         drive_cmd(cs, rd, wr, oe, addr, be, $random(seed));
      end
      drive_idle(DRAIN_CYCLES);

      assert (exp_q.size() == 0) else begin
         $display("%0d reads never came back on the bus", exp_q.size());
         oe_errs++;
      end

      $display("errors: data %0d, data_oe %0d, idle data %0d",
               data_errs, oe_errs, idle_errs);
      if (data_errs + oe_errs + idle_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- ext_mem.f
+incdir+.
ext_mem_pkg.sv
cmd_decode.sv
mem_array.sv
read_pipe.sv
ext_mem_top.sv
tb_ext_mem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the external memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_ext_mem
LOG=sim.log

echo "building $TOP"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   -f ext_mem.f --top-module "$TOP"
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

echo "running simulation"
./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   echo "RESULT: FAIL"
   exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
   echo "RESULT: FAIL (no result line in $LOG)"
   exit 1
fi

echo "RESULT: PASS"
exit 0
